//--- mandel.f
+incdir+logic
logic/mandel_pkg.sv
logic/mandel_cfg_regs.sv
logic/mandel_alu.sv
logic/mandel_pixel_engine.sv
logic/mandel_top.sv
verif/mandel_tb.sv

//--- Makefile
SRCS := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: run clean

run: obj_dir/Vmandel_tb
	./obj_dir/Vmandel_tb | tee sim.log
	grep -qx "Verification passed" sim.log

# rebuilt only when a source or the file list changes
obj_dir/Vmandel_tb: mandel.f $(SRCS)
	verilator --binary --timing --assert --top-module mandel_tb \
		-f mandel.f -o Vmandel_tb

clean:
	rm -rf obj_dir sim.log

//--- verif/mandel_tb.sv
`timescale 1ns/1ps

`include "mandel_consts.svh"

module mandel_tb
    import mandel_pkg::*;
();

    localparam int ACK_TIMEOUT  = 20;      // cycles for one config phase
    localparam int REQ_TIMEOUT  = 400;     // longest pixel plus margin
    localparam int DONE_TIMEOUT = 20;
    localparam int RUN_TIMEOUT  = 500000;  // whole test sequence
    localparam int FRAME_PIXELS = `MB_WIDTH * `MB_HEIGHT;

    logic          clk;
    logic          reset;
    logic          cfg_req;
    mandel_wr_t    cfg_wr;
    logic          cfg_ack;
    logic          pix_req;
    mandel_pixel_t pix;
    logic          pix_ack;
    logic          busy;
    logic          frame_done;

    int          seed         = 19463;
    int          mismatches   = 0;
    int          proto_errors = 0;
    int          timeouts     = 0;
    int          pix_count;         // handshakes in the current frame
    int          req_rises    = 0;  // every pix_req rise since reset
    logic        pix_req_d;
    bit          seq_done     = 1'b0;
    mandel_cfg_t view;              // settings of the running frame

    mandel_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pixels the DUT offers, counted on its own side of the handshake
    always @(posedge clk) begin
        pix_req_d <= pix_req;
        if (!reset && pix_req && !pix_req_d) begin
            req_rises <= req_rises + 1;
        end
    end

    // ==================================================
    // protocol checks
    // ==================================================
    assert property (@(posedge clk) disable iff (reset)
        (pix_req && $past(pix_req)) |-> $stable(pix))
    else begin
        proto_errors++;
        $display("pix changed while pix_req was high");
    end

    assert property (@(posedge clk) disable iff (reset)
        $rose(pix_req) |-> !$past(pix_ack))
    else begin
        proto_errors++;
        $display("pix_req rose while pix_ack was still high");
    end

    assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req))
    else begin
        proto_errors++;
        $display("cfg_ack rose without cfg_req");
    end

    assert property (@(posedge clk) disable iff (reset)
        $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
        proto_errors++;
        $display("cfg_ack fell while cfg_req was high");
    end

    assert property (@(posedge clk) disable iff (reset)
        $rose(frame_done) |-> pix_count == FRAME_PIXELS)
    else begin
        proto_errors++;
        $display("frame_done rose before the last handshake");
    end

    assert property (@(posedge clk) disable iff (reset) busy != frame_done)
    else begin
        proto_errors++;
        $display("busy and frame_done agree");
    end

    // ==================================================
    // reference model
    // ==================================================
    function automatic int wrap10(input int v);
        int w;
        w = v & 1023;
        if (w >= 512) begin
            w = w - 1024;  // back to signed
        end
        return w;
    endfunction

    function automatic int escape_count(input int cr, input int ci, input int limit);
        int  zr;
        int  zi;
        int  zr2;
        int  zi2;
        int  nr;
        int  ni;
        int  n;
        bit  ovf;
        zr  = 0;
        zi  = 0;
        ovf = 1'b0;
        for (n = 0; n < limit; n++) begin
            zr2 = (zr * zr) >>> `MB_FRAC;
            zi2 = (zi * zi) >>> `MB_FRAC;
            if (ovf || (zr2 + zi2 > (4 << `MB_FRAC))) begin
                return n;
            end
            nr  = zr2 - zi2 + cr;
            ni  = ((2 * zr * zi) >>> `MB_FRAC) + ci;
            ovf = (nr < -512) || (nr > 511) || (ni < -512) || (ni > 511);
            zr  = wrap10(nr);
            zi  = wrap10(ni);
        end
        return limit;
    endfunction

    function automatic mandel_pixel_t expected_pixel(input int x, input int y);
        int            k;
        int            n;
        mandel_pixel_t p;
        k = 1 + int'(view.scaling[0]) + 2 * int'(view.scaling[1]);
        n = escape_count(wrap10(int'(view.cr_offset) + x * k),
                         wrap10(int'(view.ci_offset) + y * k), int'(view.max_ctr));
        p.x     = 4'(x);
        p.y     = 4'(y);
        p.shade = 4'(n >> view.ctr_select);  // selected count window
        return p;
    endfunction

    function automatic mandel_cfg_t make_view(input int limit, input int sel, input int scale,
                                              input int cr_off, input int ci_off);
        mandel_cfg_t c;
        c.max_ctr    = 7'(limit);
        c.ctr_select = 2'(sel);
        c.scaling    = 2'(scale);
        c.cr_offset  = 10'(cr_off);
        c.ci_offset  = 10'(ci_off);
        return c;
    endfunction

    // ==================================================
    // helpers
    // ==================================================
    task automatic give_up(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
        @(negedge clk);  // the closing block ends the run before this edge
    endtask

    task automatic check_value(input string name, input int got, input int want);
        assert (got == want)
            else begin
                mismatches++;
                $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
            end
    endtask

    task automatic write_reg(input logic [1:0] reg_addr, input logic [15:0] reg_data);
        int t;
        cfg_wr.addr = reg_addr;
        cfg_wr.data = reg_data;
        cfg_req     = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!cfg_ack && t < ACK_TIMEOUT);
        if (!cfg_ack) begin
            give_up("cfg_ack to rise");
        end
        cfg_req = 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (cfg_ack && t < ACK_TIMEOUT);
        if (cfg_ack) begin
            give_up("cfg_ack to fall");
        end
    endtask

    // program a view, start it and accept every pixel
    task automatic run_frame(input mandel_cfg_t c, input bit poke);
        int            t;
        int            x;
        int            y;
        int            d;
        int            rises_before;
        mandel_pixel_t exp;
        write_reg(`MB_ADDR_LIMIT, {5'd0, c.scaling, c.ctr_select, c.max_ctr});
        write_reg(`MB_ADDR_CR, {6'd0, c.cr_offset});
        write_reg(`MB_ADDR_CI, {6'd0, c.ci_offset});
        view         = c;
        pix_count    = 0;
        rises_before = req_rises;
        write_reg(`MB_ADDR_CTRL, 16'h0001);
        check_value("busy", int'(busy), 1);
        for (y = 0; y < `MB_HEIGHT; y++) begin
            for (x = 0; x < `MB_WIDTH; x++) begin
                t = 0;
                while (!pix_req && t < REQ_TIMEOUT) begin
                    @(negedge clk);
                    t++;
                end
                if (!pix_req) begin
                    give_up("pix_req to rise");
                end
                exp = expected_pixel(x, y);
                check_value("pix.x", int'(pix.x), int'(exp.x));
                check_value("pix.y", int'(pix.y), int'(exp.y));
                check_value("pix.shade", int'(pix.shade), int'(exp.shade));
                if (poke && pix_count == 40) begin
                    write_reg(`MB_ADDR_CTRL, 16'h0001);   // engine busy, no restart
                    write_reg(`MB_ADDR_LIMIT, 16'h0003);  // running frame keeps its limit
                end
                d = ($random(seed) & 32'h7fff_ffff) % 6;
                repeat (d) @(negedge clk);
                pix_ack = 1'b1;
                t = 0;
                do begin
                    @(negedge clk);
                    t++;
                end while (pix_req && t < REQ_TIMEOUT);
                if (pix_req) begin
                    give_up("pix_req to fall");
                end
                d = ($random(seed) & 32'h7fff_ffff) % 6;
                repeat (d) @(negedge clk);  // sink holds ack a while
                pix_ack = 1'b0;
                pix_count++;
            end
        end
        t = 0;
        while (!frame_done && t < DONE_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!frame_done) begin
            give_up("frame_done");
        end
        repeat (20) @(negedge clk);  // an ignored start must leave the engine idle
        check_value("busy", int'(busy), 0);
        check_value("pix_req", int'(pix_req), 0);
        check_value("pix_req rises", req_rises - rises_before, FRAME_PIXELS);
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : main
        int s;
        reset     = 1'b1;
        cfg_req   = 1'b0;
        cfg_wr    = '0;
        pix_ack   = 1'b0;
        pix_count = 0;
        view      = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_value("cfg_ack", int'(cfg_ack), 0);
        check_value("pix_req", int'(pix_req), 0);
        check_value("busy", int'(busy), 0);
        check_value("frame_done", int'(frame_done), 1);

        run_frame(make_view(15, 0, 0, -128, -48), 1'b1);  // -2.0, -0.75
        for (s = 1; s < 4; s++) begin
            run_frame(make_view(127, s, 0, -50, 3), 1'b0);
        end
        run_frame(make_view(31, 1, 0, 384, 384), 1'b0);   // far out, leaves at once
        run_frame(make_view(31, 1, 1, -144, -38), 1'b0);
        run_frame(make_view(31, 2, 2, -96, -64), 1'b0);
        run_frame(make_view(31, 0, 3, 480, -512), 1'b0);  // coordinates wrap
        seq_done = 1'b1;
    end

    // ==================================================
    // end of run
    // ==================================================
    initial begin : closing
        int t;
        t = 0;
        while (!seq_done && timeouts == 0 && t < RUN_TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (!seq_done && timeouts == 0) begin
            timeouts++;
            $display("Timeout while waiting for the test sequence to end");
        end
        $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
                 mismatches, proto_errors, timeouts);
        if (mismatches + proto_errors + timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- logic/mandel_top.sv
`timescale 1ns/1ps

`include "mandel_consts.svh"

module mandel_top
    import mandel_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          cfg_req,
    input  mandel_wr_t    cfg_wr,
    output logic          cfg_ack,
    output logic          pix_req,
    output mandel_pixel_t pix,
    input  logic          pix_ack,
    output logic          busy,
    output logic          frame_done
);

    // ==================================================
    // internal wiring
    // ==================================================
    mandel_cfg_t                    cfg;
    logic                           start;
    logic signed [`MB_BITWIDTH-1:0] zr;
    logic signed [`MB_BITWIDTH-1:0] zi;
    logic signed [`MB_BITWIDTH-1:0] cr;
    logic signed [`MB_BITWIDTH-1:0] ci;
    logic signed [`MB_BITWIDTH-1:0] next_zr;
    logic signed [`MB_BITWIDTH-1:0] next_zi;
    logic                           escaped;
    logic                           overflow;

    mandel_cfg_regs regs_i (
        .clk     (clk),
        .reset   (reset),
        .cfg_req (cfg_req),
        .cfg_wr  (cfg_wr),
        .cfg_ack (cfg_ack),
        .busy    (busy),
        .cfg     (cfg),
        .start   (start)
    );

    mandel_pixel_engine engine_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .busy       (busy),
        .frame_done (frame_done),
        .zr         (zr),
        .zi         (zi),
        .cr         (cr),
        .ci         (ci),
        .next_zr    (next_zr),
        .next_zi    (next_zi),
        .escaped    (escaped),
        .overflow   (overflow),
        .pix_req    (pix_req),
        .pix        (pix),
        .pix_ack    (pix_ack)
    );

    // combinational step, result used by the engine the same cycle
    mandel_alu alu_i (
        .zr       (zr),
        .zi       (zi),
        .cr       (cr),
        .ci       (ci),
        .next_zr  (next_zr),
        .next_zi  (next_zi),
        .escaped  (escaped),
        .overflow (overflow)
    );

endmodule

//--- logic/mandel_pixel_engine.sv
`timescale 1ns/1ps

`include "mandel_consts.svh"

module mandel_pixel_engine
    import mandel_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  mandel_cfg_t                    cfg,
    output logic                           busy,
    output logic                           frame_done,
    output logic signed [`MB_BITWIDTH-1:0] zr,
    output logic signed [`MB_BITWIDTH-1:0] zi,
    output logic signed [`MB_BITWIDTH-1:0] cr,
    output logic signed [`MB_BITWIDTH-1:0] ci,
    input  logic signed [`MB_BITWIDTH-1:0] next_zr,
    input  logic signed [`MB_BITWIDTH-1:0] next_zi,
    input  logic                           escaped,
    input  logic                           overflow,
    output logic                           pix_req,
    output mandel_pixel_t                  pix,
    input  logic                           pix_ack
);

    localparam int W  = `MB_BITWIDTH;
    localparam int XB = `MB_XBITS;
    localparam int YB = `MB_YBITS;

    localparam logic [XB-1:0] X_LAST = XB'(`MB_WIDTH - 1);
    localparam logic [YB-1:0] Y_LAST = YB'(`MB_HEIGHT - 1);

    typedef enum logic [1:0] {
        ST_IDLE,     // frame finished or never started
        ST_ITER,     // one z step per clock
        ST_PRESENT,  // pix_req high, waiting for ack
        ST_RELEASE   // waiting for ack to drop
    } eng_state_t;

    eng_state_t  state;
    mandel_cfg_t cfg_q;   // frozen for the whole frame
    logic [XB-1:0]             x_q;
    logic [YB-1:0]             y_q;
    logic [`MB_CTRWIDTH-1:0]   ctr_q;
    logic                      ovf_q;  // overflow from the previous step
    logic [3:0]                shade_q;
    logic                      stop;

    // offset + coord * k, wrapping in W bits
    function automatic logic [W-1:0] map_coord(input logic [W-1:0] offset,
                                               input logic [W-1:0] coord,
                                               input logic [1:0]   scaling);
        logic [W-1:0] step;
        step = coord;
        if (scaling[0]) begin
            step = step + coord;
        end
        if (scaling[1]) begin
            step = step + (coord << 1);
        end
        return offset + step;
    endfunction

    // ==================================================
    // coordinate mapping and status
    // ==================================================
    assign cr = map_coord(cfg_q.cr_offset, W'(x_q), cfg_q.scaling);
    assign ci = map_coord(cfg_q.ci_offset, W'(y_q), cfg_q.scaling);

    assign busy       = (state != ST_IDLE);
    assign frame_done = (state == ST_IDLE);

    assign stop = (ctr_q == cfg_q.max_ctr) || escaped || ovf_q;

    assign pix = '{x: x_q, y: y_q, shade: shade_q};

    // ==================================================
    // iteration and handshake FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            pix_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        cfg_q <= cfg;
                        x_q   <= '0;
                        y_q   <= '0;
                        zr    <= '0;
                        zi    <= '0;
                        ctr_q <= '0;
                        ovf_q <= 1'b0;
                        state <= ST_ITER;
                    end
                end
                ST_ITER: begin
                    if (stop) begin
                        shade_q <= 4'(ctr_q >> cfg_q.ctr_select);  // count window
                        pix_req <= 1'b1;
                        state   <= ST_PRESENT;
                    end else begin
                        zr    <= next_zr;
                        zi    <= next_zi;
                        ctr_q <= ctr_q + 1'b1;
                        ovf_q <= overflow;
                    end
                end
                ST_PRESENT: begin
                    if (pix_ack) begin
                        pix_req <= 1'b0;
                        state   <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!pix_ack) begin
                        zr    <= '0;  // fresh z for the next point
                        zi    <= '0;
                        ctr_q <= '0;
                        ovf_q <= 1'b0;
                        if (x_q == X_LAST) begin
                            x_q <= '0;
                            y_q <= y_q + 1'b1;
                            if (y_q == Y_LAST) begin
                                state <= ST_IDLE;  // last handshake done
                            end else begin
                                state <= ST_ITER;
                            end
                        end else begin
                            x_q   <= x_q + 1'b1;
                            state <= ST_ITER;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/mandel_alu.sv
`timescale 1ns/1ps

`include "mandel_consts.svh"

module mandel_alu (
    input  logic signed [`MB_BITWIDTH-1:0] zr,
    input  logic signed [`MB_BITWIDTH-1:0] zi,
    input  logic signed [`MB_BITWIDTH-1:0] cr,
    input  logic signed [`MB_BITWIDTH-1:0] ci,
    output logic signed [`MB_BITWIDTH-1:0] next_zr,
    output logic signed [`MB_BITWIDTH-1:0] next_zi,
    output logic                           escaped,
    output logic                           overflow
);

    localparam int W = `MB_BITWIDTH;
    localparam int F = `MB_FRAC;
    localparam int SW = 2 * W + 2;  // headroom for the sums

    // 4.0 in the shifted magnitude domain
    localparam logic signed [SW-1:0] ESCAPE_LIM = SW'(4) <<< F;

    logic signed [2*W-1:0] zr_sq;   // full width products
    logic signed [2*W-1:0] zi_sq;
    logic signed [2*W-1:0] zr_zi;
    logic signed [SW-1:0]  zr_sq_s;
    logic signed [SW-1:0]  zi_sq_s;
    logic signed [SW-1:0]  sum_r;
    logic signed [SW-1:0]  sum_i;
    logic signed [SW-1:0]  mag;
    logic                  ovf_r;
    logic                  ovf_i;

    // ==================================================
    // z^2 + c
    // ==================================================
    assign zr_sq = zr * zr;
    assign zi_sq = zi * zi;
    assign zr_zi = zr * zi;

    assign zr_sq_s = SW'(zr_sq) >>> F;  // back to F fraction bits
    assign zi_sq_s = SW'(zi_sq) >>> F;

    assign sum_r = zr_sq_s - zi_sq_s + SW'(cr);
    assign sum_i = (SW'(zr_zi) >>> (F - 1)) + SW'(ci);  // 2*zr*zi, one less shift

    // escape test on the incoming z
    assign mag     = zr_sq_s + zi_sq_s;
    assign escaped = (mag > ESCAPE_LIM);

    // result fits when all bits above the sign bit agree with it
    assign ovf_r = (sum_r[SW-1:W-1] != '0) && (sum_r[SW-1:W-1] != '1);
    assign ovf_i = (sum_i[SW-1:W-1] != '0) && (sum_i[SW-1:W-1] != '1);
    assign overflow = ovf_r || ovf_i;

    assign next_zr = sum_r[W-1:0];  // truncated on overflow
    assign next_zi = sum_i[W-1:0];

endmodule

//--- logic/mandel_cfg_regs.sv
`timescale 1ns/1ps

`include "mandel_consts.svh"

module mandel_cfg_regs
    import mandel_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cfg_req,
    input  mandel_wr_t  cfg_wr,
    output logic        cfg_ack,
    input  logic        busy,
    output mandel_cfg_t cfg,
    output logic        start
);

    typedef enum logic {
        WR_IDLE,  // waiting for a request
        WR_ACK    // write taken, waiting for req to drop
    } wr_state_t;

    wr_state_t state;

    assign cfg_ack = (state == WR_ACK);

    // ==================================================
    // four-phase write responder
    // ==================================================
    always_ff @(posedge clk) begin
        start <= 1'b0;  // single-cycle pulse
        if (reset) begin
            state <= WR_IDLE;
            cfg   <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (cfg_req) begin
                        state <= WR_ACK;
                        case (cfg_wr.addr)
                            `MB_ADDR_CTRL: begin
                                // a frame already running ignores the request
                                start <= cfg_wr.data[0] && !busy;
                            end
                            `MB_ADDR_LIMIT: begin
                                cfg.max_ctr    <= cfg_wr.data[`MB_CTRWIDTH-1:0];
                                cfg.ctr_select <= cfg_wr.data[8:7];
                                cfg.scaling    <= cfg_wr.data[10:9];
                            end
                            `MB_ADDR_CR: begin
                                cfg.cr_offset <= cfg_wr.data[`MB_BITWIDTH-1:0];
                            end
                            default: begin
                                cfg.ci_offset <= cfg_wr.data[`MB_BITWIDTH-1:0];
                            end
                        endcase
                    end
                end
                WR_ACK: begin
                    if (!cfg_req) begin
                        state <= WR_IDLE;  // ack drops next cycle
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/mandel_pkg.sv
`include "mandel_consts.svh"

package mandel_pkg;

    // ==================================================
    // view configuration held by the register block
    // ==================================================
    typedef struct packed {
        logic [`MB_CTRWIDTH-1:0] max_ctr;    // iteration limit
        logic [1:0]              ctr_select; // shade window offset
        logic [1:0]              scaling;    // step k = 1 + s0 + 2*s1
        logic [`MB_BITWIDTH-1:0] cr_offset;  // real part of pixel (0,0)
        logic [`MB_BITWIDTH-1:0] ci_offset;  // imaginary part of pixel (0,0)
    } mandel_cfg_t;

    // one write on the config port
    typedef struct packed {
        logic [1:0]  addr;
        logic [15:0] data;
    } mandel_wr_t;

    // ==================================================
    // one rendered point
    // ==================================================
    typedef struct packed {
        logic [`MB_XBITS-1:0] x;
        logic [`MB_YBITS-1:0] y;
        logic [3:0]           shade;  // window of the escape count
    } mandel_pixel_t;

endpackage

//--- logic/mandel_consts.svh
`ifndef MANDEL_CONSTS_SVH
`define MANDEL_CONSTS_SVH

// ==================================================
// fixed-point format
// ==================================================
`define MB_BITWIDTH   10    // signed word, covers -8.0 .. +7.98
`define MB_FRAC       6     // fraction bits
`define MB_CTRWIDTH   7     // iteration counter

// ==================================================
// raster and register map
// ==================================================
`define MB_WIDTH      16
`define MB_HEIGHT     12
`define MB_XBITS      4
`define MB_YBITS      4

`define MB_ADDR_CTRL  2'd0  // bit 0 starts a frame
`define MB_ADDR_LIMIT 2'd1  // max_ctr, ctr_select, scaling
`define MB_ADDR_CR    2'd2
`define MB_ADDR_CI    2'd3

`endif
